// File: uart_pkg.sv
//////////////////////////////
// Register map, RX word layout, status bits and the APB write-word union.
//////////////////////////////
package uart_pkg;

    // Byte addresses, word aligned.
    localparam int ADDR_CTRL    = 'h00;
    localparam int ADDR_STATUS  = 'h04;
    localparam int ADDR_RX      = 'h08;
    localparam int ADDR_TX_BASE = 'h10;  // Channel c at base + 4*c.

    localparam int               DIV_W          = 16;
    localparam logic [DIV_W-1:0] CTRL_RESET_DIV = 16'd15;  // Bit time is divider + 1.

    // RX pop word.
    localparam int RX_VALID_BIT = 31;
    localparam int RX_PERR_BIT  = 30;
    localparam int RX_CHAN_LSB  = 16;  // Bits 23:16, data in 7:0.

    // STATUS word, overrun flags in 7:0.
    localparam int ST_CRZ_LSB = 8;
    localparam int ST_RXE_BIT = 16;

    typedef struct packed {
        logic [13:0]      rsvd;
        logic             parity_odd;
        logic             parity_en;
        logic [DIV_W-1:0] divider;
    } uart_ctrl_t;

    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  data;
    } uart_txw_t;

    // One write word, decoded by address.
    typedef union packed {
        uart_ctrl_t ctrl;
        uart_txw_t  tx;
    } uart_wdata_u;

endpackage

// File: uart_chan_if.sv
`timescale 1ns/1ps
//////////////////////////////
// Channel link between one UART channel and the host blocks.
//////////////////////////////
interface uart_chan_if #(
    parameter int BYTE_W = 8
);
    logic              tx_valid;
    logic [BYTE_W-1:0] tx_data;
    logic              tx_credit;   // One TX credit back to regs.
    logic              rx_valid;
    logic [BYTE_W-1:0] rx_data;
    logic              rx_perr;
    logic              rx_take;     // Merge took this channel's byte.
    logic              rx_credit;   // RX credit back on pop.

    modport host (
        output tx_valid, tx_data, rx_take, rx_credit,
        input  tx_credit, rx_valid, rx_data, rx_perr
    );

    modport chan (
        input  tx_valid, tx_data, rx_take, rx_credit,
        output tx_credit, rx_valid, rx_data, rx_perr
    );

endinterface

// File: uart_tx_serializer.sv
`timescale 1ns/1ps
//////////////////////////////
// UART serializer, LSB first, optional parity.
//////////////////////////////
module uart_tx_serializer
    import uart_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [DIV_W-1:0] divider_i,
    input  logic             parity_en_i,
    input  logic             parity_odd_i,
    input  logic             byte_valid_i,
    input  logic [7:0]       byte_i,
    output logic             take_o,
    output logic             txd_o
);
    logic             busy;
    logic [DIV_W-1:0] cnt;
    logic [3:0]       bits_left;
    logic [10:0]      shreg;     // Stop, parity, data, start.
    logic             bit_end;

    assign take_o  = byte_valid_i & ~busy;
    assign txd_o   = ~busy | shreg[0];  // Idle line is high.
    assign bit_end = (cnt == divider_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy      <= 1'b0;
            cnt       <= '0;
            bits_left <= '0;
        end else if (take_o) begin
            busy      <= 1'b1;
            cnt       <= '0;
            bits_left <= parity_en_i ? 4'd11 : 4'd10;
        end else if (busy) begin
            if (bit_end) begin
                cnt       <= '0;
                bits_left <= bits_left - 1'b1;
                if (bits_left == 4'd1) busy <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            // Without parity bit 9 is already the stop bit.
            shreg <= {1'b1, parity_en_i ? (^byte_i ^ parity_odd_i) : 1'b1, byte_i, 1'b0};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[10:1]};
        end
    end

endmodule

// File: uart_rx_deserializer.sv
`timescale 1ns/1ps
//////////////////////////////
// UART deserializer with mid-bit sampling and parity/stop check.
//////////////////////////////
module uart_rx_deserializer
    import uart_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [DIV_W-1:0] divider_i,
    input  logic             parity_en_i,
    input  logic             parity_odd_i,
    input  logic             rxd_i,
    output logic             valid_o,
    output logic [7:0]       data_o,
    output logic             perr_o
);
    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_START = 3'd1;
    localparam logic [2:0] S_DATA  = 3'd2;
    localparam logic [2:0] S_PAR   = 3'd3;
    localparam logic [2:0] S_STOP  = 3'd4;

    logic [1:0]       sync;
    logic             rxd;
    logic [2:0]       state;
    logic [DIV_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             par_bit;
    logic             tick;

    assign rxd  = sync[1];
    assign tick = (cnt == divider_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) sync <= 2'b11;
        else          sync <= {sync[0], rxd_i};
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state   <= S_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            cnt     <= tick ? '0 : cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (!rxd) state <= S_START;
                end
                S_START: begin
                    if (cnt == (divider_i >> 1)) begin  // Half bit, confirm start.
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= parity_en_i ? S_PAR : S_STOP;
                    end
                end
                S_PAR: begin
                    if (tick) state <= S_STOP;
                end
                S_STOP: begin
                    if (tick) begin
                        valid_o <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Missing stop bit counts as a parity error.
    always_ff @(posedge clk_i) begin
        if (state == S_DATA && tick) shreg <= {rxd, shreg[7:1]};
        if (state == S_PAR && tick) par_bit <= rxd;
        if (state == S_STOP && tick) begin
            data_o <= shreg;
            perr_o <= !rxd || (parity_en_i && (par_bit != (^shreg ^ parity_odd_i)));
        end
    end

endmodule

// File: uart_channel.sv
`timescale 1ns/1ps
//////////////////////////////
// One UART channel: TX queue, RX holding buffer, overrun and RX credit.
//////////////////////////////
module uart_channel
    import uart_pkg::*;
#(
    parameter int TX_DEPTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [DIV_W-1:0] divider_i,
    input  logic             parity_en_i,
    input  logic             parity_odd_i,
    input  logic             uart_rx_i,
    output logic             uart_tx_o,
    input  logic             ovr_clr_i,
    output logic             overrun_o,
    uart_chan_if.chan        chan
);
    localparam int PW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
    localparam int CW = $clog2(TX_DEPTH + 1);

    logic [7:0]    txq [TX_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] txq_cnt;
    logic          take;
    logic          rx_valid;
    logic [7:0]    rx_data;
    logic          rx_perr;
    logic          hold_valid;
    logic          rx_cred;

    //////////////////////////////
    // TX queue
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (chan.tx_valid) txq[wr_ptr] <= chan.tx_data;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            txq_cnt <= '0;
        end else begin
            if (chan.tx_valid) wr_ptr <= (wr_ptr == PW'(TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (take) rd_ptr <= (rd_ptr == PW'(TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            txq_cnt <= txq_cnt + CW'(chan.tx_valid) - CW'(take);
        end
    end

    assign chan.tx_credit = take;  // Slot frees as the serializer takes it.

    uart_tx_serializer i_tx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .divider_i   (divider_i),
        .parity_en_i (parity_en_i),
        .parity_odd_i(parity_odd_i),
        .byte_valid_i(txq_cnt != '0),
        .byte_i      (txq[rd_ptr]),
        .take_o      (take),
        .txd_o       (uart_tx_o)
    );

    uart_rx_deserializer i_rx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .divider_i   (divider_i),
        .parity_en_i (parity_en_i),
        .parity_odd_i(parity_odd_i),
        .rxd_i       (uart_rx_i),
        .valid_o     (rx_valid),
        .data_o      (rx_data),
        .perr_o      (rx_perr)
    );

    //////////////////////////////
    // RX holding buffer
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rx_valid && (!hold_valid || chan.rx_take)) begin
            chan.rx_data <= rx_data;
            chan.rx_perr <= rx_perr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hold_valid <= 1'b0;
            rx_cred    <= 1'b1;
            overrun_o  <= 1'b0;
        end else begin
            if (rx_valid) begin
                hold_valid <= 1'b1;
            end else if (chan.rx_take) begin
                hold_valid <= 1'b0;
            end
            if (chan.rx_take) begin
                rx_cred <= 1'b0;
            end else if (chan.rx_credit) begin
                rx_cred <= 1'b1;
            end
            // Set wins over clear.
            overrun_o <= (overrun_o & ~ovr_clr_i) | (rx_valid & hold_valid & ~chan.rx_take);
        end
    end

    assign chan.rx_valid = hold_valid & rx_cred;

    a_txq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        chan.tx_valid |-> (txq_cnt < CW'(TX_DEPTH)));

endmodule

// File: uart_rx_merge.sv
`timescale 1ns/1ps
//////////////////////////////
// Round-robin RX merge into the shared RX queue.
//////////////////////////////
module uart_rx_merge
    import uart_pkg::*;
#(
    parameter int NUM_CH   = 4,
    parameter int RX_DEPTH = 8
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    uart_chan_if.host   chan [NUM_CH],
    input  logic        pop_i,
    output logic [31:0] word_o,
    output logic        empty_o
);
    localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int PW   = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CW   = $clog2(RX_DEPTH + 1);
    localparam int EW   = 9 + CH_W;  // {perr, channel, data}.

    logic [NUM_CH-1:0] req;
    logic [NUM_CH-1:0] req_perr;
    logic [7:0]        req_data [NUM_CH];
    logic [NUM_CH-1:0] take;
    logic [CH_W-1:0]   rr;
    logic [CH_W-1:0]   sel;
    logic              found;
    logic [EW-1:0]     q [RX_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     cnt;
    logic [EW-1:0]     head;
    logic              pop;

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        assign req[c]            = chan[c].rx_valid;
        assign req_data[c]       = chan[c].rx_data;
        assign req_perr[c]       = chan[c].rx_perr;
        assign chan[c].rx_take   = take[c];
        assign chan[c].rx_credit = pop && (head[8 +: CH_W] == CH_W'(c));
    end

    // First requester at or after rr.
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = rr;
        for (int i = 0; i < NUM_CH; i++) begin
            idx = int'(rr) + i;
            if (idx >= NUM_CH) idx = idx - NUM_CH;
            if (!found && req[idx]) begin
                found = 1'b1;
                sel   = CH_W'(idx);
            end
        end
        take      = '0;
        take[sel] = found;
    end

    assign empty_o = (cnt == '0);
    assign pop     = pop_i & ~empty_o;
    assign head    = q[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (found) q[wr_ptr] <= {req_perr[sel], sel, req_data[sel]};
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr     <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (found) begin
                rr     <= (sel == CH_W'(NUM_CH - 1)) ? '0 : sel + 1'b1;
                wr_ptr <= (wr_ptr == PW'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) rd_ptr <= (rd_ptr == PW'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            cnt <= cnt + CW'(found) - CW'(pop);
        end
    end

    always_comb begin
        word_o = '0;
        if (!empty_o) begin
            word_o[RX_VALID_BIT]           = 1'b1;
            word_o[RX_PERR_BIT]            = head[EW-1];
            word_o[RX_CHAN_LSB +: CH_W]    = head[8 +: CH_W];
            word_o[7:0]                    = head[7:0];
        end
    end

    // One RX credit per channel keeps the queue from filling.
    a_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        found |-> (cnt != CW'(RX_DEPTH)));

endmodule

// File: apb_uart_regs.sv
`timescale 1ns/1ps
//////////////////////////////
// APB slave with control, status, RX pop and per-channel TX credits.
//////////////////////////////
module apb_uart_regs
    import uart_pkg::*;
#(
    parameter int NUM_CH     = 4,
    parameter int TX_DEPTH   = 8,
    parameter int APB_ADDR_W = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pslverr_o,
    uart_chan_if.host             chan [NUM_CH],
    output logic [DIV_W-1:0]      divider_o,
    output logic                  parity_en_o,
    output logic                  parity_odd_o,
    input  logic [NUM_CH-1:0]     overrun_i,
    output logic [NUM_CH-1:0]     ovr_clr_o,
    input  logic [31:0]           rx_word_i,
    output logic                  rx_pop_o,
    input  logic                  rx_empty_i
);
    localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int CRD_W = $clog2(TX_DEPTH + 1);

    uart_wdata_u           wdata;
    uart_wdata_u           ctrl_rd;
    logic                  access;
    logic                  wr_acc;
    logic                  rd_acc;
    logic                  hit_ctrl;
    logic                  hit_status;
    logic                  hit_rx;
    logic                  hit_tx;
    logic [APB_ADDR_W-1:0] tx_off;
    logic [CH_W-1:0]       tx_ch;
    logic                  tx_ok;
    logic [NUM_CH-1:0]     crd_zero;
    logic [31:0]           status;

    //////////////////////////////
    // Address decode
    //////////////////////////////
    assign wdata      = pwdata_i;
    assign access     = psel_i & penable_i;
    assign wr_acc     = access & pwrite_i;
    assign rd_acc     = access & ~pwrite_i;
    assign hit_ctrl   = (paddr_i == APB_ADDR_W'(ADDR_CTRL));
    assign hit_status = (paddr_i == APB_ADDR_W'(ADDR_STATUS));
    assign hit_rx     = (paddr_i == APB_ADDR_W'(ADDR_RX));

    assign tx_off = paddr_i - APB_ADDR_W'(ADDR_TX_BASE);
    assign hit_tx = (paddr_i >= APB_ADDR_W'(ADDR_TX_BASE)) && (tx_off[1:0] == 2'b00)
                 && ((tx_off >> 2) < APB_ADDR_W'(NUM_CH));
    assign tx_ch  = tx_off[2 +: CH_W];
    assign tx_ok  = wr_acc & hit_tx & ~crd_zero[tx_ch];

    // Unmapped address, or TX write with no credit left.
    assign pslverr_o = access & (~(hit_ctrl | hit_status | hit_rx | hit_tx)
                     | (pwrite_i & hit_tx & crd_zero[tx_ch]));

    assign rx_pop_o  = rd_acc & hit_rx & ~rx_empty_i;
    assign ovr_clr_o = (wr_acc && hit_status) ? pwdata_i[NUM_CH-1:0] : '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            divider_o    <= CTRL_RESET_DIV;
            parity_en_o  <= 1'b0;
            parity_odd_o <= 1'b0;
        end else if (wr_acc && hit_ctrl) begin
            divider_o    <= wdata.ctrl.divider;
            parity_en_o  <= wdata.ctrl.parity_en;
            parity_odd_o <= wdata.ctrl.parity_odd;
        end
    end

    //////////////////////////////
    // TX credits
    //////////////////////////////
    for (genvar c = 0; c < NUM_CH; c++) begin : g_crd
        logic [CRD_W-1:0] crd;
        logic             push;

        assign push             = tx_ok && (tx_ch == CH_W'(c));
        assign chan[c].tx_valid = push;
        assign chan[c].tx_data  = wdata.tx.data;
        assign crd_zero[c]      = (crd == '0);

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                crd <= CRD_W'(TX_DEPTH);
            end else if (push && !chan[c].tx_credit) begin
                crd <= crd - 1'b1;
            end else if (!push && chan[c].tx_credit) begin
                crd <= crd + 1'b1;
            end
        end

        // Channel never returns more credits than it was given.
        a_crd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            crd <= CRD_W'(TX_DEPTH));
    end

    //////////////////////////////
    // Read mux
    //////////////////////////////
    always_comb begin
        ctrl_rd                 = '0;
        ctrl_rd.ctrl.divider    = divider_o;
        ctrl_rd.ctrl.parity_en  = parity_en_o;
        ctrl_rd.ctrl.parity_odd = parity_odd_o;

        status                       = '0;
        status[NUM_CH-1:0]           = overrun_i;
        status[ST_CRZ_LSB +: NUM_CH] = crd_zero;
        status[ST_RXE_BIT]           = rx_empty_i;

        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o = ctrl_rd;
        end else if (hit_status) begin
            prdata_o = status;
        end else if (hit_rx) begin
            prdata_o = rx_word_i;                 // Head of the merge queue.
        end
    end

endmodule

// File: apb_uart.sv
`timescale 1ns/1ps
//////////////////////////////
// Multi-channel APB UART top.
//////////////////////////////
module apb_uart
    import uart_pkg::*;
#(
    parameter int NUM_CH     = 4,
    parameter int TX_DEPTH   = 8,
    parameter int RX_DEPTH   = 8,
    parameter int APB_ADDR_W = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pslverr_o,
    output logic [NUM_CH-1:0]     uart_tx_o,
    input  logic [NUM_CH-1:0]     uart_rx_i
);
    logic [DIV_W-1:0]  divider;
    logic              parity_en;
    logic              parity_odd;
    logic [NUM_CH-1:0] overrun;
    logic [NUM_CH-1:0] ovr_clr;
    logic [31:0]       rx_word;
    logic              rx_pop;
    logic              rx_empty;

    uart_chan_if #(.BYTE_W(8)) chan_if [NUM_CH] ();

    apb_uart_regs #(
        .NUM_CH    (NUM_CH),
        .TX_DEPTH  (TX_DEPTH),
        .APB_ADDR_W(APB_ADDR_W)
    ) i_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pslverr_o   (pslverr_o),
        .chan        (chan_if),
        .divider_o   (divider),
        .parity_en_o (parity_en),
        .parity_odd_o(parity_odd),
        .overrun_i   (overrun),
        .ovr_clr_o   (ovr_clr),
        .rx_word_i   (rx_word),
        .rx_pop_o    (rx_pop),
        .rx_empty_i  (rx_empty)
    );

    for (genvar c = 0; c < NUM_CH; c++) begin : g_chan
        uart_channel #(
            .TX_DEPTH(TX_DEPTH)
        ) i_chan (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .divider_i   (divider),
            .parity_en_i (parity_en),
            .parity_odd_i(parity_odd),
            .uart_rx_i   (uart_rx_i[c]),
            .uart_tx_o   (uart_tx_o[c]),
            .ovr_clr_i   (ovr_clr[c]),
            .overrun_o   (overrun[c]),
            .chan        (chan_if[c])
        );
    end

    uart_rx_merge #(
        .NUM_CH  (NUM_CH),
        .RX_DEPTH(RX_DEPTH)
    ) i_merge (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .chan   (chan_if),
        .pop_i  (rx_pop),
        .word_o (rx_word),
        .empty_o(rx_empty)
    );

endmodule

// File: tb_apb_uart.sv
`timescale 1ns/1ps
//////////////////////////////
// APB UART testbench: APB and UART line models, loopback switch,
// watchdog and directed tests.
//////////////////////////////
module tb_apb_uart
    import uart_pkg::*;
();
    localparam int          NUM_CH      = 4;
    localparam int          TX_DEPTH    = 8;
    localparam int          RX_DEPTH    = 8;
    localparam int          APB_ADDR_W  = 8;
    localparam int          DIV         = 15;
    localparam int          BIT_CYCLES  = DIV + 1;
    localparam int          BURST       = 3;  // Bytes per channel in the all-channel test.
    localparam int          RX_POLLS    = 11 * BIT_CYCLES * 2;
    localparam int          N_FRAMES    = NUM_CH + 3 + (TX_DEPTH + 2) + 3 + NUM_CH * BURST;
    localparam longint      WATCHDOG_NS = (longint'(N_FRAMES) * 11 * BIT_CYCLES * 4 + 16) * 10;
    localparam logic [31:0] RNG_SEED    = 32'h478f_9328;

    logic                  clk;
    logic                  rst_n;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pslverr;
    logic [NUM_CH-1:0]     uart_tx;
    logic [NUM_CH-1:0]     uart_rx;
    logic [NUM_CH-1:0]     loop_en;
    logic [NUM_CH-1:0]     drv_line;
    logic                  cfg_par_en;
    logic                  cfg_par_odd;
    logic [7:0]            exp_data [NUM_CH][64];
    logic                  exp_perr [NUM_CH][64];
    int                    exp_wr [NUM_CH];
    int                    exp_rd [NUM_CH];

    // Loopback unless a test drives the line itself.
    assign uart_rx = (uart_tx & loop_en) | (drv_line & ~loop_en);

    apb_uart #(
        .NUM_CH    (NUM_CH),
        .TX_DEPTH  (TX_DEPTH),
        .RX_DEPTH  (RX_DEPTH),
        .APB_ADDR_W(APB_ADDR_W)
    ) dut0 (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .paddr_i  (paddr),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .pwdata_i (pwdata),
        .prdata_o (prdata),
        .pslverr_o(pslverr),
        .uart_tx_o(uart_tx),
        .uart_rx_i(uart_rx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("timeout waiting for DUT");
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic logic [7:0] rand_byte();
        return 8'($urandom());
    endfunction

    function automatic logic [31:0] rx_word_of(input int ch, input logic [7:0] data,
                                               input logic perr);
        logic [31:0] w;
        w                        = '0;
        w[RX_VALID_BIT]          = 1'b1;
        w[RX_PERR_BIT]           = perr;
        w[RX_CHAN_LSB +: 8]      = 8'(ch);
        w[7:0]                   = data;
        return w;
    endfunction

    task automatic apb_transfer(input logic [APB_ADDR_W-1:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        wait_cycles(1);
        penable = 1'b1;
        #4;
        rdata = prdata;  // Mid access phase.
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input int addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(APB_ADDR_W'(addr), 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input int addr, output logic [31:0] data, output logic err);
        apb_transfer(APB_ADDR_W'(addr), 1'b0, 32'h0, data, err);
    endtask

    task automatic read_status(output logic [31:0] st);
        logic err;
        apb_read(ADDR_STATUS, st, err);
        check("pslverr", 32'(err), 0);
    endtask

    task automatic set_ctrl(input logic par_en, input logic par_odd);
        logic [31:0] word;
        logic [31:0] rd;
        logic        err;
        word = {14'h0, par_odd, par_en, 16'(DIV)};
        apb_write(ADDR_CTRL, word, err);
        check("pslverr", 32'(err), 0);
        apb_read(ADDR_CTRL, rd, err);
        check("ctrl", rd, word);
        cfg_par_en  = par_en;
        cfg_par_odd = par_odd;
    endtask

    task automatic expect_byte(input int ch, input logic [7:0] data, input logic perr);
        exp_data[ch][exp_wr[ch]] = data;
        exp_perr[ch][exp_wr[ch]] = perr;
        exp_wr[ch]++;
    endtask

    // TX write; accepted bytes come back over the loopback.
    task automatic send_tx(input int ch, input logic [7:0] data, input logic ok);
        logic err;
        apb_write(ADDR_TX_BASE + 4 * ch, {24'h0, data}, err);
        check("pslverr", 32'(err), 32'(!ok));
        if (ok) begin
            expect_byte(ch, data, 1'b0);
        end
    endtask

    task automatic drive_bit(input int ch, input logic b);
        drv_line[ch] = b;
        wait_cycles(BIT_CYCLES);
    endtask

    task automatic uart_send_frame(input int ch, input logic [7:0] data, input logic bad_par);
        logic par;
        par = ^data ^ cfg_par_odd ^ bad_par;  // Even parity gives an even count of ones.
        drive_bit(ch, 1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(ch, data[i]);
        end
        if (cfg_par_en) begin
            drive_bit(ch, par);
        end
        drive_bit(ch, 1'b1);
    endtask

    task automatic read_rx(output logic [31:0] word);
        logic err;
        int   polls;
        polls = 0;
        do begin
            apb_read(ADDR_RX, word, err);
            check("pslverr", 32'(err), 0);
            polls++;
            if (!word[RX_VALID_BIT] && polls >= RX_POLLS) begin
                stop_with_failure("no RX byte arrived within the poll limit");
            end
        end while (!word[RX_VALID_BIT]);
    endtask

    // Merged order is free across channels, kept within one.
    task automatic drain_expected(input int count);
        logic [31:0] word;
        int          ch;
        for (int n = 0; n < count; n++) begin
            read_rx(word);
            ch = int'(word[RX_CHAN_LSB +: 8]);
            check("rx_chan_in_range", 32'(ch < NUM_CH), 1);
            check("rx_byte_pending", 32'(exp_rd[ch] < exp_wr[ch]), 1);
            check("rx_word", word,
                  rx_word_of(ch, exp_data[ch][exp_rd[ch]], exp_perr[ch][exp_rd[ch]]));
            exp_rd[ch]++;
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic test_reset();
        logic [31:0] rd;
        logic        err;
        apb_read(ADDR_CTRL, rd, err);
        check("pslverr", 32'(err), 0);
        check("ctrl", rd, 32'(DIV));
        read_status(rd);
        check("status", rd, 32'(1) << ST_RXE_BIT);
        apb_read(ADDR_RX, rd, err);
        check("rx_valid", 32'(rd[RX_VALID_BIT]), 0);
    endtask

    task automatic test_loopback();
        for (int c = 0; c < NUM_CH; c++) begin
            send_tx(c, rand_byte(), 1'b1);
        end
        drain_expected(NUM_CH);
    endtask

    task automatic test_parity();
        logic [7:0] b;
        set_ctrl(1'b1, 1'b1);
        send_tx(0, rand_byte(), 1'b1);
        drain_expected(1);
        wait_cycles(2 * BIT_CYCLES);
        set_ctrl(1'b1, 1'b0);
        send_tx(1, rand_byte(), 1'b1);
        drain_expected(1);
        wait_cycles(2 * BIT_CYCLES);
        loop_en[2] = 1'b0;
        b = rand_byte();
        uart_send_frame(2, b, 1'b1);
        expect_byte(2, b, 1'b1);
        drain_expected(1);
        loop_en[2] = 1'b1;
        set_ctrl(1'b0, 1'b0);
    endtask

    task automatic test_tx_credit();
        logic [31:0] st;
        int          ch;
        ch = 3;
        // The first byte moves to the serializer at once and frees its slot.
        for (int i = 0; i <= TX_DEPTH; i++) begin
            send_tx(ch, rand_byte(), 1'b1);
        end
        send_tx(ch, rand_byte(), 1'b0);
        read_status(st);
        check("tx_credit_zero", 32'(st[ST_CRZ_LSB + ch]), 1);
        drain_expected(TX_DEPTH + 1);
        send_tx(ch, rand_byte(), 1'b1);
        drain_expected(1);
        read_status(st);
        check("tx_credit_zero", 32'(st[ST_CRZ_LSB + ch]), 0);
    endtask

    task automatic test_overrun();
        logic [7:0]  b [3];
        logic [31:0] st;
        logic [31:0] rd;
        logic        err;
        int          ch;
        int          polls;
        ch = 1;
        loop_en[ch] = 1'b0;
        for (int i = 0; i < 3; i++) begin
            b[i] = rand_byte();
            uart_send_frame(ch, b[i], 1'b0);
        end
        expect_byte(ch, b[0], 1'b0);
        expect_byte(ch, b[1], 1'b0);
        polls = 0;
        do begin
            read_status(st);
            polls++;
            if (!st[ch] && polls >= 4 * BIT_CYCLES) begin
                stop_with_failure("overrun flag was never set");
            end
        end while (!st[ch]);
        check("overrun", 32'(st[NUM_CH-1:0]), 32'(1) << ch);
        drain_expected(2);
        apb_read(ADDR_RX, rd, err);
        check("rx_valid", 32'(rd[RX_VALID_BIT]), 0);
        apb_write(ADDR_STATUS, 32'(1) << ch, err);
        check("pslverr", 32'(err), 0);
        read_status(st);
        check("overrun", 32'(st[NUM_CH-1:0]), 0);
        loop_en[ch] = 1'b1;
    endtask

    task automatic test_all_channels();
        logic [31:0] st;
        for (int k = 0; k < BURST; k++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                send_tx(c, rand_byte(), 1'b1);
            end
        end
        drain_expected(NUM_CH * BURST);
        read_status(st);
        check("overrun", 32'(st[NUM_CH-1:0]), 0);
    endtask

    initial begin
        void'($urandom(RNG_SEED));
        rst_n       = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        loop_en     = '1;
        drv_line    = '1;  // Idle line is high.
        cfg_par_en  = 1'b0;
        cfg_par_odd = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            exp_wr[c] = 0;
            exp_rd[c] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(2);

        test_reset();
        test_loopback();
        wait_cycles(2 * BIT_CYCLES);
        test_parity();
        wait_cycles(2 * BIT_CYCLES);
        test_tx_credit();
        wait_cycles(2 * BIT_CYCLES);
        test_overrun();
        wait_cycles(2 * BIT_CYCLES);
        test_all_channels();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: sources.f
uart_pkg.sv
uart_chan_if.sv
uart_tx_serializer.sv
uart_rx_deserializer.sv
uart_channel.sv
uart_rx_merge.sv
apb_uart_regs.sv
apb_uart.sv
tb_apb_uart.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run from its log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_apb_uart \
    -f sources.f -o tb_apb_uart > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_apb_uart > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
